//--- verif/uart_vectors.txt
# op a b c, fields in hex
# W offset data strb | R offset expect from_rand_queue | S data bad_stop random | T byte | I irq
I 0 0 0
R 4 0 0
R 8 FFFFFF00 0
W C 2 3
W 0 A5 1
T A5 0 0
W 0 3C 1
W 0 C3 1
T 3C 0 0
T C3 0 0
S 5A 0 0
I 1 0 0
R 8 5A 0
I 0 0 0
R 8 FFFFFF00 0
S 0 0 1
I 1 0 0
R 8 0 1
I 0 0 0
S 11 0 0
S 0 0 1
R 4 4 0
R 4 0 0
R 8 0 1
S 96 1 0
I 0 0 0
R 4 8 0
R 4 0 0
R 8 FFFFFF00 0
W C 3 3
W 0 E7 1
T E7 0 0
S 0 0 1
R 8 0 1
R 4 0 0

//--- uart_periph.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_periph.sv
verif/uart_periph_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := uart_periph_tb
RTL_TOP    := uart_periph
FILELIST   := uart_periph.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/uart_periph_tb.sv
// ----------------------------------------
// Testbench for uart_periph with DATA_WIDTH 8 and BASE_ADDR 8'h20
// Operations come from verif/uart_vectors.txt, run from the project root
// Prescale may change only while txd and rxd are idle
// ----------------------------------------
`timescale 1ns/1ns

module uart_periph_tb import uart_pkg::*; ();

    localparam logic [7:0] BASE_ADDR = 8'h20;
    localparam string      VEC_FILE  = "verif/uart_vectors.txt";

    // One line of the vector file
    typedef struct packed {
        logic [7:0] op;
        word_t      a;
        word_t      b;
        word_t      c;
    } vec_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       rxd;
    logic       txd;
    logic       irq_rx_valid;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    vec_t       vecs[$];
    // Random bytes sent on rxd, in order
    logic [7:0] rx_expect[$];
    // Bytes decoded from txd
    logic [7:0] tx_got[$];
    prescale_t  cur_prescale;
    prescale_t  max_prescale;
    int         wait_limit;
    int         errors;
    int         checks;
    integer     seed;
    logic       loaded;
    logic       frame_active;

    always #5 clk = ~clk;

    uart_periph #(
        .DATA_WIDTH (8),
        .BASE_ADDR  (BASE_ADDR)
    ) uart_periph_inst (
        .clk          (clk),
        .reset        (reset),
        .rxd          (rxd),
        .txd          (txd),
        .irq_rx_valid (irq_rx_valid),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // Read the whole file first, the watchdog needs its length
    task automatic load_vectors();
        int               fd;
        int               code;
        logic [7:0]       op;
        word_t            a;
        word_t            b;
        word_t            c;
        logic [8*128-1:0] rest;
        prescale_t        p;
        p = 16'd1;
        max_prescale = 16'd1;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open vector file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, " %h %h %h", a, b, c);
                if (code != 3) begin
                    errors++;
                    $display("Malformed vector line after %0d entries", vecs.size());
                    break;
                end
                vecs.push_back('{op: op, a: a, b: b, c: c});
                if (op == "W" && a[3:0] == REG_PRESCALE) begin
                    if (c[0]) p[7:0] = b[7:0];
                    if (c[1]) p[15:8] = b[15:8];
                    if (p > max_prescale) max_prescale = p;
                end
            end
        end
        $fclose(fd);
    endtask

    // One bus transfer, starts and ends on a falling edge
    task automatic bus_xfer(input logic [3:0] offset, input word_t wdata,
                            input strb_t wstrb, output word_t rdata);
        int n;
        n = 0;
        mem_req = '{valid: 1'b1, addr: {BASE_ADDR, 20'h0, offset}, wdata: wdata, wstrb: wstrb};
        @(negedge clk);
        while (!mem_rsp.ready && n < wait_limit) begin
            n++;
            @(negedge clk);
        end
        if (!mem_rsp.ready) begin
            errors++;
            $display("No bus response at offset %h after %0d cycles", offset, n);
        end else if (wstrb[0] && offset == REG_TX && frame_active) begin
            // Back-pressure must hold until the stop bit is over
            errors++;
            $display("Transmit write accepted while txd was still sending a frame");
        end
        rdata = mem_rsp.rdata;
        mem_req = '0;
        @(negedge clk);
    endtask

    // Start, 8 data bits LSB first, stop, then one idle bit
    task automatic send_serial(input logic [7:0] data, input logic bad_stop);
        int bit_len;
        int i;
        bit_len = 8 * int'(cur_prescale);
        rxd = 1'b0;
        repeat (bit_len) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (bit_len) @(negedge clk);
        end
        rxd = !bad_stop;
        repeat (bit_len) @(negedge clk);
        rxd = 1'b1;
        repeat (bit_len) @(negedge clk);
    endtask

    task automatic run_vector(input vec_t v);
        word_t      rdata;
        word_t      expected;
        logic [7:0] data;
        int         n;
        case (v.op)
            "W": begin
                bus_xfer(v.a[3:0], v.b, v.c[3:0], rdata);
                if (v.a[3:0] == REG_PRESCALE) begin
                    if (v.c[0]) cur_prescale[7:0] = v.b[7:0];
                    if (v.c[1]) cur_prescale[15:8] = v.b[15:8];
                end
            end
            "R": begin
                expected = v.b;
                if (v.c[0]) begin
                    if (rx_expect.size() == 0) begin
                        errors++;
                        $display("Vector expects a random byte that was never sent");
                    end else begin
                        expected = {24'h0, rx_expect.pop_front()};
                    end
                end
                bus_xfer(v.a[3:0], '0, '0, rdata);
                check_value("mem_rsp.rdata", expected, rdata);
            end
            "S": begin
                data = v.a[7:0];
                if (v.c[0]) begin
                    data = 8'($random(seed));
                    rx_expect.push_back(data);
                end
                send_serial(data, v.b[0]);
            end
            "T": begin
                n = 0;
                while (tx_got.size() == 0 && n < wait_limit) begin
                    n++;
                    @(negedge clk);
                end
                if (tx_got.size() == 0) begin
                    errors++;
                    $display("No byte decoded from txd within %0d cycles", n);
                end else begin
                    check_value("txd byte", v.a, {24'h0, tx_got.pop_front()});
                end
            end
            "I": check_value("irq_rx_valid", v.a, 32'(irq_rx_valid));
            default: begin
                errors++;
                $display("Unknown opcode %c in vector file", v.op);
            end
        endcase
    endtask

    // ----------------------------------------
    // txd frame decoder
    // ----------------------------------------
    initial begin : txd_monitor
        int         bit_len;
        int         c;
        logic       prev;
        logic       last;
        logic [9:0] frame;
        prev = 1'b1;
        wait (!reset);
        forever begin
            @(negedge clk);
            if (prev && !txd) begin
                bit_len = 8 * int'(cur_prescale);
                frame_active = 1'b1;
                frame = '0;
                last = 1'b0;
                for (c = 1; c < 10 * bit_len; c++) begin
                    @(negedge clk);
                    // Edges only on bit boundaries
                    if (txd !== last && (c % bit_len) != 0) begin
                        errors++;
                        $display("txd changed %0d clocks into a bit", c % bit_len);
                    end
                    last = txd;
                    if ((c % bit_len) == bit_len / 2) frame = {txd, frame[9:1]};
                end
                frame_active = 1'b0;
                if (frame[0] !== 1'b0 || frame[9] !== 1'b1) begin
                    errors++;
                    $display("txd frame has a bad start or stop bit");
                end
                tx_got.push_back(frame[8:1]);
            end
            prev = txd;
        end
    end

    initial begin : watchdog
        longint limit_cycles;
        wait (loaded);
        limit_cycles = longint'(vecs.size()) * 12 * 8 * longint'(max_prescale) + 1000;
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        seed = 32'h3c8fff68;
        errors = 0;
        checks = 0;
        loaded = 1'b0;
        frame_active = 1'b0;
        cur_prescale = 16'd1;
        reset = 1'b1;
        rxd = 1'b1;
        mem_req = '0;
        load_vectors();
        wait_limit = 12 * 8 * int'(max_prescale) + 100;
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        // Idle line and quiet bus out of reset
        check_value("txd", 32'h1, 32'(txd));
        check_value("mem_rsp.ready", 32'h0, 32'(mem_rsp.ready));
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- design/uart_periph.sv
// ----------------------------------------
// UART peripheral top level
// DATA_WIDTH from 5 to 8, BASE_ADDR selects the 16 MB region
// irq_rx_valid stays high while a received byte is unread
// ----------------------------------------
`timescale 1ns/1ns

module uart_periph import uart_pkg::*; #(
    parameter int         DATA_WIDTH = 8,
    parameter logic [7:0] BASE_ADDR  = 8'h20
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rxd,
    output logic     txd,
    output logic     irq_rx_valid,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    // ----------------------------------------
    // Engine links
    // ----------------------------------------
    prescale_t             prescale;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    logic                  tx_busy;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_valid;
    logic                  rx_ack;
    logic                  rx_busy;
    // Single-cycle error events from the receiver
    logic                  overrun;
    logic                  frame_err;

    uart_regs #(
        .DATA_WIDTH (DATA_WIDTH),
        .BASE_ADDR  (BASE_ADDR)
    ) uart_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_busy      (tx_busy),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ack       (rx_ack),
        .rx_busy      (rx_busy),
        .overrun      (overrun),
        .frame_err    (frame_err),
        .prescale     (prescale),
        .irq_rx_valid (irq_rx_valid)
    );

    uart_tx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uart_tx_inst (
        .clk      (clk),
        .reset    (reset),
        .prescale (prescale),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

    uart_rx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uart_rx_inst (
        .clk       (clk),
        .reset     (reset),
        .prescale  (prescale),
        .rxd       (rxd),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ack    (rx_ack),
        .rx_busy   (rx_busy),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

endmodule

//--- design/uart_regs.sv
// ----------------------------------------
// Bus decoder and register file
// Region is addr[31:24] == BASE_ADDR, offsets alias across the region
// Unused offsets and wrong directions are never answered
// A transmit write stalls the bus while the transmitter is busy
// ----------------------------------------
`timescale 1ns/1ns

module uart_regs import uart_pkg::*; #(
    parameter int         DATA_WIDTH = 8,
    parameter logic [7:0] BASE_ADDR  = 8'h20
) (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_req_t              mem_req,
    output mem_rsp_t              mem_rsp,
    output logic [DATA_WIDTH-1:0] tx_data,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    input  logic                  tx_busy,
    input  logic [DATA_WIDTH-1:0] rx_data,
    input  logic                  rx_valid,
    output logic                  rx_ack,
    input  logic                  rx_busy,
    input  logic                  overrun,
    input  logic                  frame_err,
    output prescale_t             prescale,
    output logic                  irq_rx_valid
);

    logic         ready_q;
    word_t        rdata_q;
    logic         req_hit;
    logic         is_write;
    logic [3:0]   offset;
    logic         status_rd;
    logic         frame_sticky;
    logic         overrun_sticky;
    uart_status_t status;

    assign mem_rsp = '{ready: ready_q, rdata: rdata_q};

    // New transfer in our region, not yet answered
    assign req_hit   = mem_req.valid && !ready_q && (mem_req.addr[31:24] == BASE_ADDR);
    assign is_write  = |mem_req.wstrb;
    assign offset    = mem_req.addr[3:0];
    assign status_rd = req_hit && !is_write && (offset == REG_STATUS);

    // Busy bits are live, errors are held until read
    assign status = '{
        frame_error:   frame_sticky,
        overrun_error: overrun_sticky,
        rx_busy:       rx_busy,
        tx_busy:       tx_busy
    };

    // Interrupt follows the waiting byte
    assign irq_rx_valid = rx_valid;

    // ----------------------------------------
    // Handshakes and control registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q  <= 1'b0;
            tx_valid <= 1'b0;
            rx_ack   <= 1'b0;
            prescale <= 16'd1;
        end else begin
            ready_q  <= 1'b0;
            tx_valid <= 1'b0;
            rx_ack   <= 1'b0;
            if (req_hit) begin
                case (offset)
                    REG_TX: begin
                        if (is_write) begin
                            if (!mem_req.wstrb[0]) begin
                                // No low byte, nothing to send
                                ready_q <= 1'b1;
                            end else if (tx_ready && !tx_valid) begin
                                tx_valid <= 1'b1;
                                ready_q  <= 1'b1;
                            end
                        end
                    end
                    REG_STATUS: begin
                        ready_q <= !is_write;
                    end
                    REG_RX: begin
                        if (!is_write) begin
                            rx_ack  <= rx_valid;
                            ready_q <= 1'b1;
                        end
                    end
                    REG_PRESCALE: begin
                        if (is_write) begin
                            if (mem_req.wstrb[0]) prescale[7:0]  <= mem_req.wdata[7:0];
                            if (mem_req.wstrb[1]) prescale[15:8] <= mem_req.wdata[15:8];
                            ready_q <= 1'b1;
                        end
                    end
                    default: ready_q <= 1'b0;
                endcase
            end
        end
    end

    // Sticky errors, a new event beats the clear from a status read
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_sticky   <= 1'b0;
            overrun_sticky <= 1'b0;
        end else begin
            frame_sticky   <= (frame_sticky && !status_rd) || frame_err;
            overrun_sticky <= (overrun_sticky && !status_rd) || overrun;
        end
    end

    // Read data and transmit byte
    always_ff @(posedge clk) begin
        if (req_hit && !is_write) begin
            if (offset == REG_STATUS) begin
                rdata_q <= word_t'(status);
            end else if (offset == REG_RX) begin
                rdata_q <= rx_valid ? word_t'(rx_data) : RX_EMPTY_WORD;
            end
        end
        if (req_hit && is_write && offset == REG_TX && tx_ready && !tx_valid) begin
            tx_data <= mem_req.wdata[DATA_WIDTH-1:0];
        end
    end

    // One ready pulse per transfer, the master must see it drop
    a_ready_single: assert property (
        @(posedge clk) disable iff (reset) mem_rsp.ready |=> !mem_rsp.ready
    ) else $error("ready high on two consecutive cycles");

endmodule

//--- design/uart_rx.sv
// ----------------------------------------
// Serial receiver with mid-bit sampling
// rxd is asynchronous and goes through two flops first
// No FIFO, a new byte overwrites an unread one and flags overrun
// ----------------------------------------
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  prescale_t             prescale,
    input  logic                  rxd,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    input  logic                  rx_ack,
    output logic                  rx_busy,
    output logic                  overrun,
    output logic                  frame_err
);

    rx_state_t             state;
    // Synchronizer stages and previous sample for edge detect
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  rxd_prev;
    logic [18:0]           bit_len;
    logic [18:0]           half_len;
    logic [18:0]           div_cnt;
    logic [3:0]            bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  deliver;

    assign bit_len  = {prescale, 3'b000};
    assign half_len = {1'b0, prescale, 2'b00};

    assign rx_busy  = (state != RX_IDLE);

    // Good stop bit sampled, byte goes to the output register
    assign deliver  = (state == RX_STOP) && (div_cnt == '0) && rxd_sync;

    // Idle line is high, so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RX_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            overrun   <= 1'b0;
            frame_err <= 1'b0;
            if (rx_ack) begin
                rx_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    // Falling edge, wait half a bit to land mid start bit
                    if (rxd_prev && !rxd_sync) begin
                        div_cnt <= half_len - 19'd1;
                        state   <= RX_START;
                    end
                end
                RX_START: begin
                    if (div_cnt == '0) begin
                        if (!rxd_sync) begin
                            div_cnt <= bit_len - 19'd1;
                            bit_cnt <= 4'(DATA_WIDTH - 1);
                            state   <= RX_DATA;
                        end else begin
                            // Glitch, line went back high
                            state <= RX_IDLE;
                        end
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                RX_DATA: begin
                    if (div_cnt == '0) begin
                        div_cnt <= bit_len - 19'd1;
                        if (bit_cnt == '0) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt - 4'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                RX_STOP: begin
                    if (div_cnt == '0) begin
                        state <= RX_IDLE;
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                            // An ack in this same cycle frees the old byte in time
                            overrun  <= rx_valid && !rx_ack;
                        end else begin
                            frame_err <= 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits enter at the top, LSB ends at bit 0
    always_ff @(posedge clk) begin
        if (state == RX_DATA && div_cnt == '0) begin
            shreg <= {rxd_sync, shreg[DATA_WIDTH-1:1]};
        end
        if (deliver) begin
            rx_data <= shreg;
        end
    end

    // Register block only acknowledges a byte it has seen
    a_ack_with_valid: assert property (
        @(posedge clk) disable iff (reset) rx_ack |-> rx_valid
    ) else $error("rx_ack seen without rx_valid");

endmodule

//--- design/uart_tx.sv
// ----------------------------------------
// Serial transmitter, 8N1 style frame, LSB first
// One bit lasts prescale * 8 clocks, prescale of 0 is not supported
// A byte is taken only when tx_valid and tx_ready are both high
// ----------------------------------------
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  prescale_t             prescale,
    input  logic [DATA_WIDTH-1:0] tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    output logic                  tx_busy,
    output logic                  txd
);

    tx_state_t             state;
    logic [18:0]           bit_len;
    logic [18:0]           div_cnt;
    logic [3:0]            bit_cnt;
    // Data bits still to be shifted out
    logic [DATA_WIDTH-1:0] shreg;

    // Full bit period in clocks
    assign bit_len  = {prescale, 3'b000};

    assign tx_ready = (state == TX_IDLE);
    assign tx_busy  = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_valid) begin
                        // Start bit goes out right away
                        txd     <= 1'b0;
                        div_cnt <= bit_len - 19'd1;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (div_cnt == '0) begin
                        txd     <= shreg[0];
                        bit_cnt <= 4'(DATA_WIDTH - 1);
                        div_cnt <= bit_len - 19'd1;
                        state   <= TX_DATA;
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                TX_DATA: begin
                    if (div_cnt == '0) begin
                        div_cnt <= bit_len - 19'd1;
                        if (bit_cnt == '0) begin
                            txd   <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            txd     <= shreg[1];
                            bit_cnt <= bit_cnt - 4'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                TX_STOP: begin
                    // tx_ready returns once the stop bit has run its length
                    if (div_cnt == '0) begin
                        state <= TX_IDLE;
                    end else begin
                        div_cnt <= div_cnt - 19'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload shifter, loaded on the handshake
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_valid) begin
            shreg <= tx_data;
        end else if (state == TX_DATA && div_cnt == '0) begin
            shreg <= shreg >> 1;
        end
    end

    // Register block must wait for tx_ready before it pulses tx_valid
    a_no_valid_when_busy: assert property (
        @(posedge clk) disable iff (reset) tx_valid |-> tx_ready
    ) else $error("tx_valid arrived while transmitter busy");

endmodule

//--- design/uart_pkg.sv
// ----------------------------------------
// Shared types for the UART peripheral
// Bus structs follow the valid/ready memory bus of the CPU
// Register offsets decode only address bits [3:0]
// ----------------------------------------

package uart_pkg;

    // Bus word for addresses and data
    typedef logic [31:0] word_t;
    // One write strobe per byte lane
    typedef logic [3:0] strb_t;
    // Clocks per eighth of a serial bit
    typedef logic [15:0] prescale_t;

    // Request from the bus master, 69 bits
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t wdata;
        strb_t wstrb;
    } mem_req_t;

    // Response from the peripheral, 33 bits
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

    // Status bits as seen in the low nibble of the status word
    typedef struct packed {
        logic frame_error;
        logic overrun_error;
        logic rx_busy;
        logic tx_busy;
    } uart_status_t;

    // ----------------------------------------
    // Register map, byte offsets in the region
    // ----------------------------------------
    localparam logic [3:0] REG_TX       = 4'h0;
    localparam logic [3:0] REG_STATUS   = 4'h4;
    localparam logic [3:0] REG_RX       = 4'h8;
    localparam logic [3:0] REG_PRESCALE = 4'hC;

    // Receive register read while nothing is waiting
    localparam word_t RX_EMPTY_WORD = 32'hFFFF_FF00;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage
